//--- Bender.yml
package:
  name: apu

sources:
  - rtl/apu_pkg.sv
  - rtl/apu_regs.sv
  - rtl/frame_sequencer.sv
  - rtl/square_channel.sv
  - rtl/wave_channel.sv
  - rtl/apu_output_stage.sv
  - rtl/apu_top.sv
  - target: simulation
    files:
      - verif/apu_checker.sv
      - verif/apu_assert.sv
      - verif/apu_tb.sv

//--- rtl/apu_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

module apu_output_stage import apu_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire [data_w-1:0]   master_vol,
    input  wire [data_w-1:0]   panning,
    input  wire [data_w-1:0]   power,
    input  wire [sample_w-1:0] square_sample,
    input  wire [sample_w-1:0] wave_sample,
    output logic               pwm_out
);

    logic              square_left;
    logic              wave_left;
    logic [sample_w:0] left_sum;     // two 4-bit samples
    logic [level_w:0]  scaled;       // sum * vol * 2, at most 480
    logic [level_w-1:0] level;
    logic [level_w-1:0] pwm_count;

    assign square_left = panning[5];
    assign wave_left   = panning[6];

    always_comb begin
        left_sum = '0;
        if (square_left) begin
            left_sum = left_sum + square_sample;
        end
        if (wave_left) begin
            left_sum = left_sum + wave_sample;
        end
        scaled = left_sum * ({1'b0, master_vol[2:0]} + 4'd1) * 2'd2;
    end

    // average over the enabled left channels, 1 or 2
    always_comb begin
        if (!power[7] || !(square_left || wave_left)) begin
            level = '0;
        end else if (square_left && wave_left) begin
            level = scaled[level_w:1];
        end else begin
            level = scaled[level_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_count <= '0;
        end else begin
            pwm_count <= pwm_count + 1'b1;   // free running
        end
    end

    assign pwm_out = pwm_count < level;

endmodule

`default_nettype wire

//--- rtl/apu_pkg.sv
`default_nettype none

package apu_pkg;

    // bus and datapath widths
    localparam int addr_w   = 16;
    localparam int data_w   = 8;
    localparam int sample_w = 4;
    localparam int level_w  = 8;
    localparam int freq_w   = 11;

    // register addresses still decoded
    typedef enum logic [addr_w-1:0] {
        nr21 = 16'hFF16,   // square duty / length
        nr22 = 16'hFF17,   // square envelope
        nr23 = 16'hFF18,   // square freq lo
        nr24 = 16'hFF19,   // square freq hi + trigger
        nr30 = 16'hFF1A,   // wave dac enable
        nr31 = 16'hFF1B,   // wave length, write only
        nr32 = 16'hFF1C,   // wave volume code
        nr33 = 16'hFF1D,   // wave freq lo
        nr34 = 16'hFF1E,   // wave freq hi + trigger
        nr50 = 16'hFF24,   // master volume
        nr51 = 16'hFF25,   // panning
        nr52 = 16'hFF26    // power
    } apu_reg_e;

    // wave ram window, 32 nibbles
    localparam logic [addr_w-1:0] wave_ram_base  = 16'hFF30;
    localparam int                wave_ram_bytes = 16;

    localparam logic [data_w-1:0] unmapped_read = 8'hAA;

    // duty patterns, 12.5 / 25 / 50 / 75 percent
    localparam logic [3:0][7:0] duty_table = {8'hFC, 8'h0F, 8'h03, 8'h01};

    // timer period is (freq_period_base - freq) * mult
    localparam int freq_period_base  = 2048;
    localparam int square_timer_mult = 4;
    localparam int wave_timer_mult   = 2;

    // frame sequencer, 512 Hz off the system counter
    localparam int fs_bit        = 12;
    localparam int envelope_step = 7;

endpackage

`default_nettype wire

//--- rtl/apu_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apu_regs import apu_pkg::*; (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [addr_w-1:0]                addr,
    input  wire                              write_en,
    input  wire  [data_w-1:0]                write_data,
    output logic [data_w-1:0]                read_data,
    output logic [data_w-1:0]                nr21,
    output logic [data_w-1:0]                nr22,
    output logic [data_w-1:0]                nr23,
    output logic [data_w-1:0]                nr24,
    output logic [data_w-1:0]                nr30,
    output logic [data_w-1:0]                nr32,
    output logic [data_w-1:0]                nr33,
    output logic [data_w-1:0]                nr34,
    output logic [data_w-1:0]                nr50,
    output logic [data_w-1:0]                nr51,
    output logic [data_w-1:0]                nr52,
    output logic [wave_ram_bytes*data_w-1:0] wave_ram,
    output logic                             square_trigger,
    output logic                             wave_trigger
);

    // the ports share names with the enum members, so case labels are qualified
    logic [data_w-1:0] nr31;   // length byte, nothing consumes it
    logic [data_w-1:0] wave_mem [wave_ram_bytes];
    logic [addr_w-1:0] wave_off;
    logic              wave_hit;

    assign wave_off = addr - wave_ram_base;
    assign wave_hit = (addr >= wave_ram_base) &&
                      (addr < wave_ram_base + addr_w'(wave_ram_bytes));

    // flat view for the wave channel
    always_comb begin
        for (int i = 0; i < wave_ram_bytes; i++) begin
            wave_ram[i*data_w +: data_w] = wave_mem[i];
        end
    end

    always_comb begin
        if (wave_hit) begin
            read_data = wave_mem[wave_off[$clog2(wave_ram_bytes)-1:0]];
        end else begin
            case (addr)
                apu_pkg::nr21: read_data = nr21 | 8'h3F;
                apu_pkg::nr22: read_data = nr22;
                apu_pkg::nr23: read_data = nr23 | 8'hFF;
                apu_pkg::nr24: read_data = nr24 | 8'hBF;   // only length enable shows
                apu_pkg::nr30: read_data = nr30;
                apu_pkg::nr31: read_data = nr31 | 8'hFF;
                apu_pkg::nr32: read_data = nr32;
                apu_pkg::nr33: read_data = nr33 | 8'hFF;
                apu_pkg::nr34: read_data = nr34 | 8'hBF;
                apu_pkg::nr50: read_data = nr50;
                apu_pkg::nr51: read_data = nr51;
                apu_pkg::nr52: read_data = nr52 | 8'h70;
                default:       read_data = unmapped_read;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nr21 <= '0;
            nr22 <= '1;
            nr23 <= '1;
            nr24 <= '1;
            nr30 <= '0;
            nr31 <= '0;
            nr32 <= '1;
            nr33 <= '1;
            nr34 <= '1;
            nr50 <= '0;
            nr51 <= '0;
            nr52 <= '0;
            for (int i = 0; i < wave_ram_bytes; i++) begin
                wave_mem[i] <= '0;
            end
        end else if (write_en) begin
            if (wave_hit) begin
                wave_mem[wave_off[$clog2(wave_ram_bytes)-1:0]] <= write_data;
            end else begin
                case (addr)
                    apu_pkg::nr21: nr21 <= write_data;
                    apu_pkg::nr22: nr22 <= write_data;
                    apu_pkg::nr23: nr23 <= write_data;
                    apu_pkg::nr24: nr24 <= write_data;
                    apu_pkg::nr30: nr30 <= write_data;
                    apu_pkg::nr31: nr31 <= write_data;
                    apu_pkg::nr32: nr32 <= write_data;
                    apu_pkg::nr33: nr33 <= write_data;
                    apu_pkg::nr34: nr34 <= write_data;
                    apu_pkg::nr50: nr50 <= write_data;
                    apu_pkg::nr51: nr51 <= write_data;
                    apu_pkg::nr52: nr52 <= write_data;
                    default: ;   // unmapped, dropped
                endcase
            end
        end
    end

    // bit 7 of a freq hi write restarts the channel, one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            square_trigger <= 1'b0;
            wave_trigger   <= 1'b0;
        end else begin
            square_trigger <= write_en && (addr == apu_pkg::nr24) && write_data[7];
            wave_trigger   <= write_en && (addr == apu_pkg::nr34) && write_data[7];
        end
    end

endmodule

`default_nettype wire

//--- rtl/apu_top.sv
`timescale 1ns/10ps
`default_nettype none

module apu_top import apu_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire  [addr_w-1:0]  addr,
    input  wire                write_en,
    input  wire  [data_w-1:0]  write_data,
    output logic [data_w-1:0]  read_data,
    input  wire  [31:0]        sys_counter,
    output logic               pwm_out
);

    logic [data_w-1:0]                nr21, nr22, nr23, nr24;
    logic [data_w-1:0]                nr30, nr32, nr33, nr34;
    logic [data_w-1:0]                nr50, nr51, nr52;
    logic [wave_ram_bytes*data_w-1:0] wave_ram;
    logic                             square_trigger;
    logic                             wave_trigger;
    logic                             envelope_tick;
    logic [sample_w-1:0]              square_sample;
    logic [sample_w-1:0]              wave_sample;

    apu_regs i_regs (
        .clk, .rst, .addr, .write_en, .write_data, .read_data,
        .nr21, .nr22, .nr23, .nr24,
        .nr30, .nr32, .nr33, .nr34,
        .nr50, .nr51, .nr52,
        .wave_ram, .square_trigger, .wave_trigger
    );

    frame_sequencer i_frame_seq (.clk, .rst, .sys_counter, .envelope_tick);

    square_channel i_square (
        .clk, .rst,
        .duty_len      (nr21),
        .envelope      (nr22),
        .freq_lo       (nr23),
        .freq_hi       (nr24),
        .trigger       (square_trigger),
        .envelope_tick,
        .sample        (square_sample)
    );

    wave_channel i_wave (
        .clk, .rst,
        .dac_ctrl (nr30),
        .vol_code (nr32),
        .freq_lo  (nr33),
        .freq_hi  (nr34),
        .wave_ram,
        .trigger  (wave_trigger),
        .sample   (wave_sample)
    );

    apu_output_stage i_output (
        .clk, .rst,
        .master_vol (nr50),
        .panning    (nr51),
        .power      (nr52),
        .square_sample,
        .wave_sample,
        .pwm_out
    );

endmodule

`default_nettype wire

//--- rtl/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sequencer import apu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire [31:0] sys_counter,
    output logic       envelope_tick
);

    logic       prev_bit;   // counter bit one cycle back
    logic [2:0] step;
    logic       fs_fall;

    assign fs_fall = prev_bit && !sys_counter[fs_bit];

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_bit      <= 1'b0;
            step          <= '0;
            envelope_tick <= 1'b0;
        end else begin
            prev_bit <= sys_counter[fs_bit];
            if (fs_fall) begin
                step <= step + 3'd1;   // wraps 7 -> 0
            end
            // pulse together with entry into the envelope step
            envelope_tick <= fs_fall && (step == 3'(envelope_step - 1));
        end
    end

endmodule

`default_nettype wire

//--- rtl/square_channel.sv
`timescale 1ns/10ps
`default_nettype none

module square_channel import apu_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [data_w-1:0]   duty_len,
    input  wire  [data_w-1:0]   envelope,
    input  wire  [data_w-1:0]   freq_lo,
    input  wire  [data_w-1:0]   freq_hi,
    input  wire                 trigger,
    input  wire                 envelope_tick,
    output logic [sample_w-1:0] sample
);

    logic [freq_w-1:0]   freq;
    logic [freq_w+2:0]   timer_reload;   // up to 2048 * 4
    logic [freq_w+2:0]   freq_timer;
    logic [2:0]          duty_pos;
    logic [sample_w-1:0] volume;
    logic [2:0]          env_timer;
    logic [2:0]          env_period;
    logic                env_up;
    logic                duty_bit;

    assign freq         = {freq_hi[2:0], freq_lo};
    assign timer_reload = (freq_w+3)'((freq_period_base - freq) * square_timer_mult);
    assign env_period   = envelope[2:0];
    assign env_up       = envelope[3];
    assign duty_bit     = duty_table[duty_len[7:6]][duty_pos];

    // frequency timer steps through the 8 duty positions
    always_ff @(posedge clk) begin
        if (rst) begin
            freq_timer <= '0;
            duty_pos   <= '0;
        end else if (freq_timer == '0) begin
            freq_timer <= timer_reload;
            duty_pos   <= duty_pos + 3'd1;
        end else begin
            freq_timer <= freq_timer - 1'b1;
        end
    end

    // volume envelope
    always_ff @(posedge clk) begin
        if (rst) begin
            volume    <= '0;
            env_timer <= '0;
        end else if (trigger) begin
            volume    <= envelope[7:4];   // initial volume
            env_timer <= env_period;
        end else if (envelope_tick && env_period != 3'd0) begin
            if (env_timer <= 3'd1) begin
                env_timer <= env_period;
                if (env_up && volume != '1) begin
                    volume <= volume + 1'b1;
                end else if (!env_up && volume != '0) begin
                    volume <= volume - 1'b1;
                end
            end else begin
                env_timer <= env_timer - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample <= '0;
        end else begin
            sample <= duty_bit ? volume : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wave_channel.sv
`timescale 1ns/10ps
`default_nettype none

module wave_channel import apu_pkg::*; (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire  [data_w-1:0]                   dac_ctrl,
    input  wire  [data_w-1:0]                   vol_code,
    input  wire  [data_w-1:0]                   freq_lo,
    input  wire  [data_w-1:0]                   freq_hi,
    input  wire  [wave_ram_bytes*data_w-1:0]    wave_ram,
    input  wire                                 trigger,
    output logic [sample_w-1:0]                 sample
);

    logic [freq_w-1:0]   freq;
    logic [freq_w+1:0]   timer_reload;   // up to 2048 * 2
    logic [freq_w+1:0]   freq_timer;
    logic [3:0]          pos;            // byte index into wave ram
    logic                low_nibble;
    logic [data_w-1:0]   cur_byte;
    logic [sample_w-1:0] nibble;
    logic [1:0]          shift_code;

    assign freq         = {freq_hi[2:0], freq_lo};
    assign timer_reload = (freq_w+2)'((freq_period_base - freq) * wave_timer_mult);
    assign cur_byte     = wave_ram[data_w*pos +: data_w];
    assign nibble       = low_nibble ? cur_byte[sample_w-1:0] : cur_byte[data_w-1:sample_w];
    assign shift_code   = vol_code[6:5];

    always_ff @(posedge clk) begin
        if (rst) begin
            freq_timer <= '0;
            pos        <= '0;
            low_nibble <= 1'b0;
        end else if (trigger) begin
            pos        <= '0;   // restart at byte 0, high nibble
            low_nibble <= 1'b0;
        end else if (freq_timer == '0) begin
            freq_timer <= timer_reload;
            low_nibble <= !low_nibble;
            if (low_nibble) begin
                pos <= pos + 4'd1;
            end
        end else begin
            freq_timer <= freq_timer - 1'b1;
        end
    end

    // code 1 full, 2 half, 3 quarter, 0 mute
    always_ff @(posedge clk) begin
        if (rst) begin
            sample <= '0;
        end else if (!dac_ctrl[7] || shift_code == 2'd0) begin
            sample <= '0;
        end else begin
            sample <= nibble >> (shift_code - 2'd1);
        end
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/apu_pkg.sv
rtl/apu_regs.sv
rtl/frame_sequencer.sv
rtl/square_channel.sv
rtl/wave_channel.sv
rtl/apu_output_stage.sv
rtl/apu_top.sv
verif/apu_checker.sv
verif/apu_assert.sv
verif/apu_tb.sv

//--- verif/apu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module apu_assert (
    input wire       clk,
    input wire       rst,
    input wire       square_trigger,
    input wire       wave_trigger,
    input wire       envelope_tick,
    input wire       pwm_out,
    input wire [7:0] nr52
);

    int fail_count = 0;

    square_pulse: assert property (@(posedge clk) disable iff (rst)
        square_trigger |=> !square_trigger)
        else begin
            fail_count++;
            $error("square_trigger high for two cycles");
        end

    wave_pulse: assert property (@(posedge clk) disable iff (rst)
        wave_trigger |=> !wave_trigger)
        else begin
            fail_count++;
            $error("wave_trigger high for two cycles");
        end

    tick_pulse: assert property (@(posedge clk) disable iff (rst)
        envelope_tick |=> !envelope_tick)
        else begin
            fail_count++;
            $error("envelope_tick high for two cycles");
        end

    // powered down means a silent output
    power_off_silent: assert property (@(posedge clk) disable iff (rst)
        !nr52[7] |-> !pwm_out)
        else begin
            fail_count++;
            $error("pwm_out high while NR52 bit 7 is clear");
        end

endmodule

bind apu_top apu_assert i_assert (
    .clk            (clk),
    .rst            (rst),
    .square_trigger (square_trigger),
    .wave_trigger   (wave_trigger),
    .envelope_tick  (envelope_tick),
    .pwm_out        (pwm_out),
    .nr52           (nr52)
);

`default_nettype wire

//--- verif/apu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module apu_checker (
    input  wire        clk,
    input  wire        rst,
    input  wire [15:0] addr,
    input  wire        write_en,
    input  wire [7:0]  write_data,
    input  wire [7:0]  read_data,
    input  wire        pwm_out,
    input  wire        window,
    input  wire [1:0]  mode,
    output int         error_count
);

    logic [7:0]  regs [256];   // model of the 0xFFxx page
    logic [15:0] high_count;   // pwm_out high cycles in the open window
    logic        window_q;

    // read-back value as a bus master should see it
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        if (a >= 16'hFF30 && a <= 16'hFF3F) begin
            return regs[a[7:0]];
        end
        case (a)
            16'hFF16:                                     return regs[8'h16] | 8'h3F;
            16'hFF18, 16'hFF1B, 16'hFF1D:                 return 8'hFF;   // write only
            16'hFF19, 16'hFF1E:                           return regs[a[7:0]] | 8'hBF;
            16'hFF17, 16'hFF1A, 16'hFF1C, 16'hFF24, 16'hFF25: return regs[a[7:0]];
            16'hFF26:                                     return regs[8'h26] | 8'h70;
            default:                                      return 8'hAA;
        endcase
    endfunction

    // mix level with the wave channel alone on the left
    function automatic int wave_level();
        logic [3:0] nib;
        logic [1:0] code;
        int         sample;
        nib  = regs[8'h30][7:4];
        code = regs[8'h1C][6:5];
        if (!regs[8'h1A][7] || code == 2'd0) begin
            sample = 0;
        end else begin
            sample = nib >> (code - 1);
        end
        if (!regs[8'h26][7] || !regs[8'h25][6]) begin
            return 0;
        end
        return sample * (regs[8'h24][2:0] + 1) * 2;
    endfunction

    initial error_count = 0;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                regs[i] <= 8'h00;
            end
            regs[8'h17] <= 8'hFF;
            regs[8'h18] <= 8'hFF;
            regs[8'h19] <= 8'hFF;
            regs[8'h1C] <= 8'hFF;
            regs[8'h1D] <= 8'hFF;
            regs[8'h1E] <= 8'hFF;
            window_q    <= 1'b0;
            high_count  <= '0;
        end else begin
            if (read_data !== expected_read(addr)) begin
                error_count++;
                $display("[FAIL] read_data @%h: expected %h got %h",
                         addr, expected_read(addr), read_data);
            end
            if (write_en && addr[15:8] == 8'hFF) begin
                regs[addr[7:0]] <= write_data;
            end
            window_q <= window;
            if (window) begin
                high_count <= high_count + pwm_out;
            end else if (window_q) begin
                high_count <= '0;
                case (mode)
                    2'd1: if (high_count != 16'(wave_level())) begin   // exact level
                        error_count++;
                        $display("[FAIL] pwm_out high cycles: expected %h got %h",
                                 16'(wave_level()), high_count);
                    end
                    2'd2: if (high_count != '0) begin   // silent
                        error_count++;
                        $display("[FAIL] pwm_out high cycles: expected %h got %h",
                                 16'h0000, high_count);
                    end
                    2'd3: if (high_count == '0) begin
                        error_count++;
                        $display("error: pwm_out never went high during the window");
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/apu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apu_tb;

    localparam int win_level   = 1;   // high count must equal the mix level
    localparam int win_silent  = 2;
    localparam int win_active  = 3;   // at least one high cycle
    localparam int counter_bit = 12;
    // rough length of each test in cycles with resets included
    localparam int test_cycles = 200 + 100 + 600 + 1500 + 1000 + 700;
    localparam int cycle_limit = 2 * test_cycles;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] addr;
    logic        write_en;
    logic [7:0]  write_data;
    wire  [7:0]  read_data;
    logic [31:0] sys_counter;
    wire         pwm_out;
    logic        window;
    logic [1:0]  mode;
    int          error_count;
    integer      seed;
    int          fs_step;   // sequencer step as expected here
    int          cycle_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_before = 0;
    // kept registers with NR52 last so it can be left out
    logic [15:0] kept_addrs [12] = '{16'hFF16, 16'hFF17, 16'hFF18, 16'hFF19, 16'hFF1A,
        16'hFF1B, 16'hFF1C, 16'hFF1D, 16'hFF1E, 16'hFF24, 16'hFF25, 16'hFF26};

    always #2 clk = ~clk;

    apu_top i_dut (.clk, .rst, .addr, .write_en, .write_data, .read_data, .sys_counter, .pwm_out);

    apu_checker i_checker (
        .clk, .rst, .addr, .write_en, .write_data, .read_data,
        .pwm_out, .window, .mode, .error_count
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int total_errors();
        return error_count + i_dut.i_assert.fail_count;
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        write_en = 1'b0;
        sys_counter = '0;
        fs_step = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        addr = a;
        write_data = d;
        write_en = 1'b1;
        @(negedge clk);
        write_en = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] a);
        addr = a;
        @(negedge clk);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one falling edge of the counter bit over four cycles
    task automatic counter_fall();
        sys_counter[counter_bit] = 1'b1;
        @(negedge clk);
        sys_counter[counter_bit] = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic envelope_ticks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            if (fs_step == 6) seen++;   // 6 -> 7 clocks the envelope
            fs_step = (fs_step + 1) % 8;
            counter_fall();
        end
    endtask

    task automatic open_window(input int m);
        mode = 2'(m);
        window = 1'b1;
    endtask

    task automatic close_window();
        window = 1'b0;
        @(negedge clk);   // checker judges the window here
    endtask

    task automatic measure(input int m, input int n);
        open_window(m);
        wait_cycles(n);
        close_window();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = total_errors() - errs_before;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("%s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
        errs_before = total_errors();
    endtask

    task automatic square_start(input logic [7:0] env);
        write_reg(16'hFF26, 8'h80);
        write_reg(16'hFF25, 8'h20);   // square on the left only
        write_reg(16'hFF24, 8'h07);
        write_reg(16'hFF16, 8'h80);   // 50 percent duty
        write_reg(16'hFF17, env);
        write_reg(16'hFF19, 8'h87);   // trigger at freq 2047
    endtask

    task automatic test_readback();
        logic [31:0] r;
        logic [31:0] d;
        logic [15:0] a;
        apply_reset();
        repeat (64) begin
            r = $random(seed);
            d = $random(seed);
            a = r[0] ? kept_addrs[r[11:8] % 12] : r[31:16];
            write_reg(a, d[7:0]);
            read_reg(a);
        end
    endtask

    task automatic test_wave_ram();
        logic [31:0] r;
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            write_reg(16'hFF30 + 16'(i), r[7:0]);
        end
        for (int i = 0; i < 16; i++) begin
            read_reg(16'hFF30 + 16'(i));
        end
    endtask

    task automatic test_power_off();
        logic [31:0] r;
        apply_reset();
        write_reg(16'hFF26, 8'h00);
        write_reg(16'hFF25, 8'h60);   // both channels on the left
        write_reg(16'hFF17, 8'hF0);   // loud square
        write_reg(16'hFF19, 8'h87);
        open_window(win_silent);
        repeat (256) begin
            r = $random(seed);
            write_reg(kept_addrs[r[11:8] % 11], r[7:0]);
            read_reg(16'hFF26);
        end
        close_window();
    endtask

    task automatic test_wave_level();
        logic [31:0] r;
        logic [3:0]  v;
        logic [1:0]  code;
        apply_reset();
        repeat (4) begin
            r = $random(seed);
            v = r[3:0];
            code = (r[5:4] == 2'd0) ? 2'd3 : r[5:4];
            for (int i = 0; i < 16; i++) begin
                write_reg(16'hFF30 + 16'(i), {v, v});
            end
            write_reg(16'hFF26, 8'h80);
            write_reg(16'hFF25, 8'h40);   // wave on the left only
            write_reg(16'hFF24, r[15:8]);
            write_reg(16'hFF1C, {1'b0, code, 5'd0});
            write_reg(16'hFF1A, 8'h80);
            write_reg(16'hFF1E, 8'h87);
            wait_cycles(64);
            measure(win_level, 256);
        end
    endtask

    task automatic test_square_decay();
        apply_reset();
        square_start(8'hF1);   // volume 15 going down with period 1
        open_window(win_active);
        envelope_ticks(14);
        close_window();
        envelope_ticks(2);
        wait_cycles(64);
        measure(win_silent, 256);
    endtask

    task automatic test_square_quiet();
        apply_reset();
        square_start(8'h08);   // volume 0 going up with no period
        open_window(win_silent);
        envelope_ticks(3);
        wait_cycles(160);
        close_window();
        square_start(8'h09);   // volume 0 going up with period 1
        envelope_ticks(2);
        measure(win_active, 256);
    endtask

    initial begin
        seed = 32'h0d54a26e;
        rst = 1'b1;
        addr = '0;
        write_en = 1'b0;
        write_data = '0;
        sys_counter = '0;
        window = 1'b0;
        mode = '0;
        test_readback();
        finish_test("register readback");
        test_wave_ram();
        finish_test("wave ram readback");
        test_power_off();
        finish_test("power off silence");
        test_wave_level();
        finish_test("wave channel level");
        test_square_decay();
        finish_test("square envelope decay");
        test_square_quiet();
        finish_test("square silent and rise");
        $display("tests: %0d run, %0d failed, errors: %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
